// ==== hdl/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32
`define ALU_OP_WIDTH 12

// one-hot alu operation bits
`define ALU_ADD 0
`define ALU_SUB 1
`define ALU_SLT 2
`define ALU_SLTU 3
`define ALU_AND 4
`define ALU_NOR 5
`define ALU_OR 6
`define ALU_XOR 7
`define ALU_SLL 8
`define ALU_SRL 9
`define ALU_SRA 10
`define ALU_LUI 11

`define OP_SPECIAL 6'h00
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDI 6'h08
`define OP_ADDIU 6'h09
`define OP_SLTI 6'h0a
`define OP_SLTIU 6'h0b
`define OP_ANDI 6'h0c
`define OP_ORI 6'h0d
`define OP_XORI 6'h0e
`define OP_LUI 6'h0f
`define OP_LW 6'h23
`define OP_SW 6'h2b

// function codes under OP_SPECIAL
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_SRA 6'h03
`define FN_SLLV 6'h04
`define FN_SRLV 6'h06
`define FN_SRAV 6'h07
`define FN_JR 6'h08
`define FN_ADD 6'h20
`define FN_ADDU 6'h21
`define FN_SUB 6'h22
`define FN_SUBU 6'h23
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_XOR 6'h26
`define FN_NOR 6'h27
`define FN_SLT 6'h2a
`define FN_SLTU 6'h2b

`define EXC_RESERVED 5'h0a

`endif

// ==== hdl/decode_pkg.sv ====
package decode_pkg;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [15:0] immediate;
  } i_fields_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [25:0] target;
  } j_fields_t;

  // same word, format chosen by opcode
  typedef union packed {
    r_fields_t r_format;
    i_fields_t i_format;
    j_fields_t j_format;
  } instruction_word_t;

endpackage

// ==== hdl/instruction_decoder.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module instruction_decoder (
  input decode_pkg::instruction_word_t instruction,
  output logic register_write,
  output logic memory_read,
  output logic memory_write,
  output logic source2_is_immediate,
  output logic source2_is_unsigned,
  output logic source1_is_shift_amount,
  output logic source1_is_pc,
  output logic [`ALU_OP_WIDTH-1:0] alu_operation,
  output logic do_overflow_check,
  output logic rt_is_used,
  output logic is_branch,
  output logic is_jump_register,
  output logic is_link,
  output logic [`REG_ADDR_WIDTH-1:0] write_register,
  output logic reserved
);
  wire [5:0] opcode = instruction.r_format.opcode;
  wire [5:0] funct = instruction.r_format.funct;
  wire special = (opcode == `OP_SPECIAL);
  wire rs_zero = (instruction.r_format.rs == '0);
  wire rt_zero = (instruction.r_format.rt == '0);
  wire rd_zero = (instruction.r_format.rd == '0);
  wire shamt_zero = (instruction.r_format.shamt == '0);

  // register ops need shamt zero, constant shifts need rs zero
  wire alu_r = special & shamt_zero;
  wire shift_r = special & rs_zero;

  wire i_add = alu_r & (funct == `FN_ADD);
  wire i_addu = alu_r & (funct == `FN_ADDU);
  wire i_sub = alu_r & (funct == `FN_SUB);
  wire i_subu = alu_r & (funct == `FN_SUBU);
  wire i_and = alu_r & (funct == `FN_AND);
  wire i_or = alu_r & (funct == `FN_OR);
  wire i_xor = alu_r & (funct == `FN_XOR);
  wire i_nor = alu_r & (funct == `FN_NOR);
  wire i_slt = alu_r & (funct == `FN_SLT);
  wire i_sltu = alu_r & (funct == `FN_SLTU);
  wire i_sllv = alu_r & (funct == `FN_SLLV);
  wire i_srlv = alu_r & (funct == `FN_SRLV);
  wire i_srav = alu_r & (funct == `FN_SRAV);
  wire i_sll = shift_r & (funct == `FN_SLL);
  wire i_srl = shift_r & (funct == `FN_SRL);
  wire i_sra = shift_r & (funct == `FN_SRA);
  wire i_jr = alu_r & rt_zero & rd_zero & (funct == `FN_JR);
  wire i_addi = (opcode == `OP_ADDI);
  wire i_addiu = (opcode == `OP_ADDIU);
  wire i_andi = (opcode == `OP_ANDI);
  wire i_ori = (opcode == `OP_ORI);
  wire i_xori = (opcode == `OP_XORI);
  wire i_slti = (opcode == `OP_SLTI);
  wire i_sltiu = (opcode == `OP_SLTIU);
  wire i_lui = (opcode == `OP_LUI) & rs_zero;
  wire i_lw = (opcode == `OP_LW);
  wire i_sw = (opcode == `OP_SW);
  wire i_beq = (opcode == `OP_BEQ);
  wire i_bne = (opcode == `OP_BNE);
  wire i_j = (opcode == `OP_J);
  wire i_jal = (opcode == `OP_JAL);

  wire alu_reg_op = i_add | i_addu | i_sub | i_subu | i_and | i_or | i_xor | i_nor
                  | i_slt | i_sltu | i_sllv | i_srlv | i_srav | i_sll | i_srl | i_sra;
  wire alu_imm_op = i_addi | i_addiu | i_andi | i_ori | i_xori | i_slti | i_sltiu | i_lui;

  // jal adds through the adder to build its link address
  assign alu_operation[`ALU_ADD] = i_add | i_addu | i_addi | i_addiu | i_lw | i_sw | i_jal;
  assign alu_operation[`ALU_SUB] = i_sub | i_subu;
  assign alu_operation[`ALU_SLT] = i_slt | i_slti;
  assign alu_operation[`ALU_SLTU] = i_sltu | i_sltiu;
  assign alu_operation[`ALU_AND] = i_and | i_andi;
  assign alu_operation[`ALU_NOR] = i_nor;
  assign alu_operation[`ALU_OR] = i_or | i_ori;
  assign alu_operation[`ALU_XOR] = i_xor | i_xori;
  assign alu_operation[`ALU_SLL] = i_sll | i_sllv;
  assign alu_operation[`ALU_SRL] = i_srl | i_srlv;
  assign alu_operation[`ALU_SRA] = i_sra | i_srav;
  assign alu_operation[`ALU_LUI] = i_lui;

  assign register_write = alu_reg_op | alu_imm_op | i_lw | i_jal;
  assign memory_read = i_lw;
  assign memory_write = i_sw;
  assign source2_is_immediate = alu_imm_op | i_lw | i_sw;
  assign source2_is_unsigned = i_andi | i_ori | i_xori;
  assign source1_is_shift_amount = i_sll | i_srl | i_sra;
  assign source1_is_pc = i_jal;
  assign do_overflow_check = i_add | i_addi | i_sub;
  assign rt_is_used = alu_reg_op | i_beq | i_bne | i_sw;
  assign is_branch = i_beq | i_bne;
  assign is_jump_register = i_jr;
  assign is_link = i_jal;

  assign write_register = i_jal ? `REG_ADDR_WIDTH'(31) :
                          (alu_imm_op | i_lw) ? instruction.i_format.rt :
                          instruction.r_format.rd;

  assign reserved = ~(alu_reg_op | alu_imm_op | i_lw | i_sw | i_beq | i_bne | i_j | i_jal | i_jr);
endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module register_file (
  input logic clock,
  input logic [`REG_ADDR_WIDTH-1:0] read_address_1,
  input logic [`REG_ADDR_WIDTH-1:0] read_address_2,
  input logic write_enable,
  input logic [`REG_ADDR_WIDTH-1:0] write_address,
  input logic [`DATA_WIDTH-1:0] write_data,
  output logic [`DATA_WIDTH-1:0] read_data_1,
  output logic [`DATA_WIDTH-1:0] read_data_2
);
  logic [`DATA_WIDTH-1:0] registers [`REG_COUNT];

  always_ff @(posedge clock) begin
    if (write_enable && write_address != '0) begin
      registers[write_address] <= write_data;
    end
  end

  // register 0 is hardwired
  always_comb begin
    if (read_address_1 == '0) begin
      read_data_1 = '0;
    end else begin
      read_data_1 = registers[read_address_1];
    end
  end

  always_comb begin
    if (read_address_2 == '0) begin
      read_data_2 = '0;
    end else begin
      read_data_2 = registers[read_address_2];
    end
  end
endmodule

// ==== hdl/operand_forward.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module operand_forward (
  input logic [`REG_ADDR_WIDTH-1:0] rs,
  input logic [`REG_ADDR_WIDTH-1:0] rt,
  input logic rt_is_used,
  input logic [`DATA_WIDTH-1:0] file_data_1,
  input logic [`DATA_WIDTH-1:0] file_data_2,
  input logic ex_valid,
  input logic ex_data_valid,
  input logic [`REG_ADDR_WIDTH-1:0] ex_write_register,
  input logic [`DATA_WIDTH-1:0] ex_write_data,
  input logic wb_write_enable,
  input logic [`REG_ADDR_WIDTH-1:0] wb_write_register,
  input logic [`DATA_WIDTH-1:0] wb_write_data,
  output logic [`DATA_WIDTH-1:0] source_value,
  output logic [`DATA_WIDTH-1:0] target_value,
  output logic stall
);
  wire ex_ready = ex_valid && ex_data_valid && ex_write_register != '0;
  wire wb_ready = wb_write_enable && wb_write_register != '0;
  // execute result still in flight, e.g. a load
  wire ex_pending = ex_valid && !ex_data_valid && ex_write_register != '0;

  function automatic logic [`DATA_WIDTH-1:0] pick(
    input logic [`REG_ADDR_WIDTH-1:0] address,
    input logic [`DATA_WIDTH-1:0] file_data
  );
    if (ex_ready && ex_write_register == address) begin
      return ex_write_data;
    end else if (wb_ready && wb_write_register == address) begin
      return wb_write_data;
    end
    return file_data;
  endfunction

  always_comb begin
    source_value = pick(rs, file_data_1);
    target_value = pick(rt, file_data_2);
  end

  assign stall = ex_pending &&
                 (ex_write_register == rs || (rt_is_used && ex_write_register == rt));
endmodule

// ==== hdl/branch_resolve.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module branch_resolve (
  input decode_pkg::instruction_word_t instruction,
  input logic [`DATA_WIDTH-1:0] pc,
  input logic [`DATA_WIDTH-1:0] source_value,
  input logic [`DATA_WIDTH-1:0] target_value,
  input logic is_branch,
  input logic is_jump_register,
  output logic taken,
  output logic [`DATA_WIDTH-1:0] target
);
  wire [5:0] opcode = instruction.j_format.opcode;
  wire [15:0] offset = instruction.i_format.immediate;
  wire direct_jump = (opcode == `OP_J) || (opcode == `OP_JAL);
  wire operands_equal = (source_value == target_value);
  wire [`DATA_WIDTH-1:0] pc_plus_4 = pc + `DATA_WIDTH'(4);
  wire [`DATA_WIDTH-1:0] branch_offset = {{(`DATA_WIDTH - 18){offset[15]}}, offset, 2'b00};

  // bne takes the inverse of beq
  assign taken = (is_branch && (operands_equal ^ (opcode == `OP_BNE))) ||
                 direct_jump || is_jump_register;

  always_comb begin
    if (is_branch) begin
      target = pc_plus_4 + branch_offset;
    end else if (is_jump_register) begin
      target = source_value;
    end else begin
      // region bits from the delay slot address
      target = {pc_plus_4[`DATA_WIDTH-1:`DATA_WIDTH-4], instruction.j_format.target, 2'b00};
    end
  end
endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input decode_pkg::instruction_word_t fetch_instruction,
  input logic [`DATA_WIDTH-1:0] fetch_pc,
  input logic execute_allow_in,
  input logic flush,
  input logic ex_valid,
  input logic ex_data_valid,
  input logic [`REG_ADDR_WIDTH-1:0] ex_write_register,
  input logic [`DATA_WIDTH-1:0] ex_write_data,
  input logic wb_write_enable,
  input logic [`REG_ADDR_WIDTH-1:0] wb_write_register,
  input logic [`DATA_WIDTH-1:0] wb_write_data,
  output logic decode_allow_in,
  output logic issue_valid,
  output logic [`DATA_WIDTH-1:0] issue_pc,
  output logic [`DATA_WIDTH-1:0] source_value,
  output logic [`DATA_WIDTH-1:0] target_value,
  output logic [15:0] immediate,
  output logic [`REG_ADDR_WIDTH-1:0] write_register,
  output logic register_write,
  output logic memory_read,
  output logic memory_write,
  output logic source2_is_immediate,
  output logic source2_is_unsigned,
  output logic source1_is_shift_amount,
  output logic source1_is_pc,
  output logic [`ALU_OP_WIDTH-1:0] alu_operation,
  output logic do_overflow_check,
  output logic exception_valid,
  output logic [4:0] exception_code,
  output logic branch_taken,
  output logic [`DATA_WIDTH-1:0] branch_target
);
  logic stage_valid;
  decode_pkg::instruction_word_t stage_instruction;
  logic [`DATA_WIDTH-1:0] stage_pc;
  logic rt_is_used, is_branch, is_jump_register, is_link, reserved, stall, taken;
  logic [`DATA_WIDTH-1:0] file_data_1, file_data_2, forwarded_target;

  wire ready_go = !stall;
  assign decode_allow_in = !stage_valid || (ready_go && execute_allow_in);
  assign issue_valid = stage_valid && ready_go;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      stage_valid <= 1'b0;
    end else if (decode_allow_in) begin
      stage_valid <= fetch_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid && decode_allow_in) begin
      stage_instruction <= fetch_instruction;
      stage_pc <= fetch_pc;
    end
  end

  instruction_decoder u_decoder (
    .instruction(stage_instruction), .register_write(register_write),
    .memory_read(memory_read), .memory_write(memory_write),
    .source2_is_immediate(source2_is_immediate), .source2_is_unsigned(source2_is_unsigned),
    .source1_is_shift_amount(source1_is_shift_amount), .source1_is_pc(source1_is_pc),
    .alu_operation(alu_operation), .do_overflow_check(do_overflow_check),
    .rt_is_used(rt_is_used), .is_branch(is_branch), .is_jump_register(is_jump_register),
    .is_link(is_link), .write_register(write_register), .reserved(reserved)
  );

  register_file u_register_file (
    .clock(clock), .read_address_1(stage_instruction.r_format.rs),
    .read_address_2(stage_instruction.r_format.rt), .write_enable(wb_write_enable),
    .write_address(wb_write_register), .write_data(wb_write_data),
    .read_data_1(file_data_1), .read_data_2(file_data_2)
  );

  operand_forward u_forward (
    .rs(stage_instruction.r_format.rs), .rt(stage_instruction.r_format.rt),
    .rt_is_used(rt_is_used), .file_data_1(file_data_1), .file_data_2(file_data_2),
    .ex_valid(ex_valid), .ex_data_valid(ex_data_valid),
    .ex_write_register(ex_write_register), .ex_write_data(ex_write_data),
    .wb_write_enable(wb_write_enable), .wb_write_register(wb_write_register),
    .wb_write_data(wb_write_data), .source_value(source_value),
    .target_value(forwarded_target), .stall(stall)
  );

  branch_resolve u_branch (
    .instruction(stage_instruction), .pc(stage_pc), .source_value(source_value),
    .target_value(forwarded_target), .is_branch(is_branch),
    .is_jump_register(is_jump_register), .taken(taken), .target(branch_target)
  );

  // jal link address is pc + 8 in execute
  assign target_value = is_link ? `DATA_WIDTH'(8) : forwarded_target;
  assign issue_pc = stage_pc;
  assign immediate = stage_instruction.i_format.immediate;
  assign exception_valid = stage_valid && reserved;
  assign exception_code = reserved ? `EXC_RESERVED : 5'h00;
  assign branch_taken = stage_valid && taken;
endmodule

// ==== bench/decode_stage_properties.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage_properties (
  input logic clock,
  input logic reset,
  input logic flush,
  input logic ex_valid,
  input logic ex_data_valid,
  input logic [`REG_ADDR_WIDTH-1:0] ex_write_register,
  input logic [`REG_ADDR_WIDTH-1:0] rs,
  input logic [`REG_ADDR_WIDTH-1:0] rt,
  input logic rt_is_used,
  input logic issue_valid,
  input logic execute_allow_in,
  input logic branch_taken,
  input logic [`DATA_WIDTH-1:0] issue_pc
);
  int failures = 0;

  // pending execute result on a source the instruction reads
  wire hazard = ex_valid && !ex_data_valid && ex_write_register != '0 &&
                (ex_write_register == rs || (rt_is_used && ex_write_register == rt));

  empty_after_reset: assert property (@(posedge clock) reset |=> !issue_valid)
    else begin
      failures++;
      $error("issue_valid high in the cycle after reset");
    end

  taken_cleared_by_flush: assert property (@(posedge clock) disable iff (reset)
    flush |=> !branch_taken)
    else begin
      failures++;
      $error("branch_taken high in the cycle after a flush");
    end

  no_issue_in_stall: assert property (@(posedge clock) disable iff (reset)
    hazard |-> !issue_valid)
    else begin
      failures++;
      $error("issue_valid high during a data hazard stall");
    end

  // back-pressure holds the instruction in place
  held_pc_stable: assert property (@(posedge clock) disable iff (reset)
    issue_valid && !execute_allow_in |=> $stable(issue_pc))
    else begin
      failures++;
      $error("issue_pc changed while execute held the stage");
    end
endmodule

bind decode_stage decode_stage_properties i_properties (
  .clock(clock), .reset(reset), .flush(flush), .ex_valid(ex_valid),
  .ex_data_valid(ex_data_valid), .ex_write_register(ex_write_register),
  .rs(stage_instruction.r_format.rs), .rt(stage_instruction.r_format.rt),
  .rt_is_used(rt_is_used), .issue_valid(issue_valid), .execute_allow_in(execute_allow_in),
  .branch_taken(branch_taken), .issue_pc(issue_pc)
);

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage_tb;
  localparam time PERIOD = 40;
  localparam time TIMEOUT = 6 * 60 * PERIOD;

  logic clock, reset, fetch_valid, execute_allow_in, flush;
  decode_pkg::instruction_word_t fetch_instruction;
  logic [`DATA_WIDTH-1:0] fetch_pc, ex_write_data, wb_write_data;
  logic ex_valid, ex_data_valid, wb_write_enable;
  logic [`REG_ADDR_WIDTH-1:0] ex_write_register, wb_write_register, write_register;
  logic decode_allow_in, issue_valid, register_write, memory_read, memory_write;
  logic source2_is_immediate, source2_is_unsigned, source1_is_shift_amount, source1_is_pc;
  logic do_overflow_check, exception_valid, branch_taken;
  logic [`DATA_WIDTH-1:0] issue_pc, source_value, target_value, branch_target;
  logic [15:0] immediate;
  logic [`ALU_OP_WIDTH-1:0] alu_operation;
  logic [4:0] exception_code;
  integer seed;

  decode_stage i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog expired before the directed tests finished");
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

  task automatic check_word(input string name, input logic [`DATA_WIDTH-1:0] actual,
                            input logic [`DATA_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_register(input string name, input logic [`REG_ADDR_WIDTH-1:0] actual,
                                input logic [`REG_ADDR_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic decode_pkg::instruction_word_t r_word(input logic [4:0] rs,
    input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt,
    input logic [5:0] funct);
    decode_pkg::instruction_word_t word;
    word.r_format = '{`OP_SPECIAL, rs, rt, rd, shamt, funct};
    return word;
  endfunction

  function automatic decode_pkg::instruction_word_t i_word(input logic [5:0] opcode,
    input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] value);
    decode_pkg::instruction_word_t word;
    word.i_format = '{opcode, rs, rt, value};
    return word;
  endfunction

  function automatic decode_pkg::instruction_word_t j_word(input logic [5:0] opcode,
    input logic [25:0] index);
    decode_pkg::instruction_word_t word;
    word.j_format = '{opcode, index};
    return word;
  endfunction

  // pc + 4 plus the word offset
  function automatic logic [`DATA_WIDTH-1:0] branch_target_of(
    input logic [`DATA_WIDTH-1:0] pc, input logic [15:0] offset);
    logic signed [`DATA_WIDTH-1:0] delta;
    delta = $signed(offset);
    return pc + `DATA_WIDTH'(4) + delta * 4;
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] jump_target_of(
    input logic [`DATA_WIDTH-1:0] pc, input logic [25:0] index);
    logic [`DATA_WIDTH-1:0] next_pc;
    next_pc = pc + `DATA_WIDTH'(4);
    return (next_pc & 32'hf000_0000) | (`DATA_WIDTH'(index) * 4);
  endfunction

  task automatic drive_point();
    @(posedge clock);
    #2;
  endtask

  // offer one instruction and hold it until decode accepts it
  task automatic send_instruction(input decode_pkg::instruction_word_t word,
                                  input logic [`DATA_WIDTH-1:0] pc);
    drive_point();
    fetch_valid = 1'b1;
    fetch_instruction = word;
    fetch_pc = pc;
    @(negedge clock);
    while (!decode_allow_in) begin
      @(negedge clock);
    end
    drive_point();
    fetch_valid = 1'b0;
  endtask

  task automatic write_back(input logic [`REG_ADDR_WIDTH-1:0] address,
                            input logic [`DATA_WIDTH-1:0] value);
    drive_point();
    wb_write_enable = 1'b1;
    wb_write_register = address;
    wb_write_data = value;
    drive_point();
    wb_write_enable = 1'b0;
  endtask

  task automatic check_alu_op(input decode_pkg::instruction_word_t word, input integer alu_bit,
                              input logic imm, input logic uns, input logic ovf,
                              input logic shift, input logic [`REG_ADDR_WIDTH-1:0] dest);
    send_instruction(word, 32'h0000_1000);
    @(negedge clock);
    check_bit("issue_valid", issue_valid, 1'b1);
    check_word("alu_operation", `DATA_WIDTH'(alu_operation), `DATA_WIDTH'(1) << alu_bit);
    check_bit("source2_is_immediate", source2_is_immediate, imm);
    check_bit("source2_is_unsigned", source2_is_unsigned, uns);
    check_bit("do_overflow_check", do_overflow_check, ovf);
    check_bit("source1_is_shift_amount", source1_is_shift_amount, shift);
    check_bit("source1_is_pc", source1_is_pc, 1'b0);
    check_bit("memory_read", memory_read, 1'b0);
    check_bit("memory_write", memory_write, 1'b0);
    check_bit("register_write", register_write, 1'b1);
    check_register("write_register", write_register, dest);
    check_word("immediate", `DATA_WIDTH'(immediate), `DATA_WIDTH'(word.i_format.immediate));
    check_bit("exception_valid", exception_valid, 1'b0);
  endtask

  task automatic check_memory_op(input decode_pkg::instruction_word_t word, input logic load);
    send_instruction(word, 32'h0000_1200);
    @(negedge clock);
    check_bit("memory_read", memory_read, load);
    check_bit("memory_write", memory_write, !load);
    check_bit("register_write", register_write, load);
    check_bit("source2_is_immediate", source2_is_immediate, 1'b1);
    check_word("alu_operation", `DATA_WIDTH'(alu_operation), `DATA_WIDTH'(1) << `ALU_ADD);
    check_word("immediate", `DATA_WIDTH'(immediate), 32'h0000_0040);
    if (load) begin
      check_register("write_register", write_register, 5'd8);
    end
  endtask

  task automatic alu_decode_test();
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_ADD), `ALU_ADD, 0, 0, 1, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_ADDU), `ALU_ADD, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_SUB), `ALU_SUB, 0, 0, 1, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_SUBU), `ALU_SUB, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_AND), `ALU_AND, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_OR), `ALU_OR, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_XOR), `ALU_XOR, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_NOR), `ALU_NOR, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_SLT), `ALU_SLT, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_SLTU), `ALU_SLTU, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd0, 5'd2, 5'd3, 5'd7, `FN_SLL), `ALU_SLL, 0, 0, 0, 1, 5'd3);
    check_alu_op(r_word(5'd0, 5'd2, 5'd3, 5'd7, `FN_SRL), `ALU_SRL, 0, 0, 0, 1, 5'd3);
    check_alu_op(r_word(5'd0, 5'd2, 5'd3, 5'd7, `FN_SRA), `ALU_SRA, 0, 0, 0, 1, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_SLLV), `ALU_SLL, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_SRLV), `ALU_SRL, 0, 0, 0, 0, 5'd3);
    check_alu_op(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_SRAV), `ALU_SRA, 0, 0, 0, 0, 5'd3);
    check_alu_op(i_word(`OP_ADDI, 5'd1, 5'd4, 16'h8123), `ALU_ADD, 1, 0, 1, 0, 5'd4);
    check_alu_op(i_word(`OP_ADDIU, 5'd1, 5'd4, 16'h8123), `ALU_ADD, 1, 0, 0, 0, 5'd4);
    check_alu_op(i_word(`OP_ANDI, 5'd1, 5'd4, 16'h8123), `ALU_AND, 1, 1, 0, 0, 5'd4);
    check_alu_op(i_word(`OP_ORI, 5'd1, 5'd4, 16'h8123), `ALU_OR, 1, 1, 0, 0, 5'd4);
    check_alu_op(i_word(`OP_XORI, 5'd1, 5'd4, 16'h8123), `ALU_XOR, 1, 1, 0, 0, 5'd4);
    check_alu_op(i_word(`OP_SLTI, 5'd1, 5'd4, 16'h8123), `ALU_SLT, 1, 0, 0, 0, 5'd4);
    check_alu_op(i_word(`OP_SLTIU, 5'd1, 5'd4, 16'h8123), `ALU_SLTU, 1, 0, 0, 0, 5'd4);
    check_alu_op(i_word(`OP_LUI, 5'd0, 5'd4, 16'h8123), `ALU_LUI, 1, 0, 0, 0, 5'd4);
    check_memory_op(i_word(`OP_LW, 5'd1, 5'd8, 16'h0040), 1'b1);
    check_memory_op(i_word(`OP_SW, 5'd1, 5'd8, 16'h0040), 1'b0);
  endtask

  task automatic register_file_test();
    logic [`DATA_WIDTH-1:0] value_a, value_b;
    value_a = $random(seed);
    value_b = $random(seed);
    write_back(5'd5, value_a);
    write_back(5'd6, value_b);
    // a write to register 0 is dropped
    write_back(5'd0, 32'hffff_ffff);
    send_instruction(r_word(5'd5, 5'd6, 5'd7, 5'd0, `FN_ADD), 32'h0000_1100);
    @(negedge clock);
    check_word("source_value", source_value, value_a);
    check_word("target_value", target_value, value_b);
    send_instruction(r_word(5'd0, 5'd5, 5'd7, 5'd0, `FN_OR), 32'h0000_1104);
    @(negedge clock);
    check_word("source_value", source_value, 32'h0);
    check_word("target_value", target_value, value_a);
  endtask

  task automatic forwarding_test();
    logic [`DATA_WIDTH-1:0] file_value, wb_value, ex_value;
    file_value = $random(seed);
    wb_value = $random(seed);
    ex_value = $random(seed);
    write_back(5'd9, file_value);
    execute_allow_in = 1'b0;
    send_instruction(r_word(5'd9, 5'd9, 5'd10, 5'd0, `FN_ADD), 32'h0000_2000);
    @(negedge clock);
    check_word("source_value", source_value, file_value);
    drive_point();
    wb_write_enable = 1'b1;
    wb_write_register = 5'd9;
    wb_write_data = wb_value;
    @(negedge clock);
    check_word("source_value", source_value, wb_value);
    check_word("target_value", target_value, wb_value);
    drive_point();
    ex_valid = 1'b1;
    ex_data_valid = 1'b1;
    ex_write_register = 5'd9;
    ex_write_data = ex_value;
    @(negedge clock);
    check_word("source_value", source_value, ex_value);
    check_word("target_value", target_value, ex_value);
    drive_point();
    ex_valid = 1'b0;
    wb_write_enable = 1'b0;
    execute_allow_in = 1'b1;
    // the write-back value is in the file by now
    @(negedge clock);
    check_word("source_value", source_value, wb_value);
  endtask

  task automatic load_use_test();
    logic [`DATA_WIDTH-1:0] load_value;
    integer stall_cycles;
    load_value = $random(seed);
    stall_cycles = 2 + ({$random(seed)} % 4);
    drive_point();
    ex_valid = 1'b1;
    ex_data_valid = 1'b0;
    ex_write_register = 5'd12;
    send_instruction(r_word(5'd13, 5'd12, 5'd14, 5'd0, `FN_SUB), 32'h0000_3000);
    repeat (stall_cycles) begin
      @(negedge clock);
      check_bit("issue_valid", issue_valid, 1'b0);
      check_bit("decode_allow_in", decode_allow_in, 1'b0);
    end
    drive_point();
    ex_data_valid = 1'b1;
    ex_write_data = load_value;
    execute_allow_in = 1'b0;
    @(negedge clock);
    while (!issue_valid) begin
      @(negedge clock);
    end
    check_word("target_value", target_value, load_value);
    drive_point();
    @(negedge clock);
    check_bit("issue_valid", issue_valid, 1'b1);
    check_bit("decode_allow_in", decode_allow_in, 1'b0);
    check_word("issue_pc", issue_pc, 32'h0000_3000);
    drive_point();
    ex_valid = 1'b0;
    execute_allow_in = 1'b1;
  endtask

  task automatic check_branch(input decode_pkg::instruction_word_t word,
                              input logic [`DATA_WIDTH-1:0] pc, input logic expect_taken,
                              input logic [`DATA_WIDTH-1:0] expect_target);
    send_instruction(word, pc);
    @(negedge clock);
    check_bit("branch_taken", branch_taken, expect_taken);
    if (expect_taken) begin
      check_word("branch_target", branch_target, expect_target);
    end
  endtask

  task automatic branch_test();
    logic [`DATA_WIDTH-1:0] value;
    value = $random(seed);
    write_back(5'd15, value);
    write_back(5'd16, value);
    write_back(5'd17, value ^ 32'h1);
    check_branch(i_word(`OP_BEQ, 5'd15, 5'd16, 16'h0010), 32'h0000_4000, 1'b1,
                 branch_target_of(32'h0000_4000, 16'h0010));
    check_branch(i_word(`OP_BEQ, 5'd15, 5'd17, 16'h0010), 32'h0000_4010, 1'b0, 32'h0);
    check_branch(i_word(`OP_BNE, 5'd15, 5'd17, 16'hfff0), 32'h0000_4020, 1'b1,
                 branch_target_of(32'h0000_4020, 16'hfff0));
    check_branch(i_word(`OP_BNE, 5'd15, 5'd16, 16'hfff0), 32'h0000_4030, 1'b0, 32'h0);
    check_branch(j_word(`OP_J, 26'h0abcdef), 32'hb000_0100, 1'b1,
                 jump_target_of(32'hb000_0100, 26'h0abcdef));
    check_branch(j_word(`OP_JAL, 26'h1234567), 32'h2fff_fffc, 1'b1,
                 jump_target_of(32'h2fff_fffc, 26'h1234567));
    check_register("write_register", write_register, 5'd31);
    check_bit("register_write", register_write, 1'b1);
    check_bit("source1_is_pc", source1_is_pc, 1'b1);
    check_branch(r_word(5'd15, 5'd0, 5'd0, 5'd0, `FN_JR), 32'h0000_4040, 1'b1, value);
  endtask

  task automatic exception_flush_test();
    send_instruction(32'hfc00_0000, 32'h0000_5000);
    @(negedge clock);
    check_bit("exception_valid", exception_valid, 1'b1);
    check_word("exception_code", `DATA_WIDTH'(exception_code), `DATA_WIDTH'(`EXC_RESERVED));
    send_instruction(r_word(5'd1, 5'd2, 5'd3, 5'd0, `FN_AND), 32'h0000_5004);
    execute_allow_in = 1'b0;
    @(negedge clock);
    check_bit("issue_valid", issue_valid, 1'b1);
    drive_point();
    flush = 1'b1;
    drive_point();
    flush = 1'b0;
    execute_allow_in = 1'b1;
    @(negedge clock);
    check_bit("issue_valid", issue_valid, 1'b0);
    check_bit("decode_allow_in", decode_allow_in, 1'b1);
  endtask

  initial begin
    seed = 32'h170c825f;
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch_instruction = '0;
    fetch_pc = '0;
    execute_allow_in = 1'b1;
    flush = 1'b0;
    ex_valid = 1'b0;
    ex_data_valid = 1'b0;
    ex_write_register = '0;
    ex_write_data = '0;
    wb_write_enable = 1'b0;
    wb_write_register = '0;
    wb_write_data = '0;
    repeat (10) @(posedge clock);
    #2;
    reset = 1'b0;
    @(negedge clock);
    check_bit("issue_valid", issue_valid, 1'b0);
    check_bit("branch_taken", branch_taken, 1'b0);
    check_bit("decode_allow_in", decode_allow_in, 1'b1);
    alu_decode_test();
    register_file_test();
    forwarding_test();
    load_use_test();
    branch_test();
    exception_flush_test();
    if (i_dut.i_properties.failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end
endmodule

// ==== mips_decode.f ====
+incdir+hdl
hdl/decode_pkg.sv
hdl/instruction_decoder.sv
hdl/register_file.sv
hdl/operand_forward.sv
hdl/branch_resolve.sv
hdl/decode_stage.sv
bench/decode_stage_properties.sv
bench/decode_stage_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = decode_stage_tb
FILE_LIST = mips_decode.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
